// ==== all.f ====
common/main_mem_pkg.sv
hw/dram_ui/dram_ui_fsm.sv
hw/dram_ui/dram_ui_cmd_stage.sv
hw/dram_ui/dram_ui.sv
hw/main_mem.sv
test/tb_clock.sv
test/app_port_model.sv
test/tb_main_mem.sv

// ==== common/main_mem_pkg.sv ====
// main memory shared definitions
// widths, vector types, cache and controller request structs, sequencer states
package main_mem_pkg;

    // cache side widths
    localparam int LINE_WIDTH       = 128;
    localparam int CACHE_ADDR_WIDTH = 32;

    // controller application port widths
    localparam int APP_ADDR_WIDTH   = 27;
    localparam int APP_CMD_WIDTH    = 3;

    typedef logic [LINE_WIDTH-1:0]       line_t;
    typedef logic [CACHE_ADDR_WIDTH-1:0] cache_addr_t;
    typedef logic [APP_ADDR_WIDTH-1:0]   app_addr_t;
    typedef logic [APP_CMD_WIDTH-1:0]    app_cmd_t;

    // controller command encodings
    localparam app_cmd_t CMD_WRITE = 3'b000;
    localparam app_cmd_t CMD_READ  = 3'b001;

    // cache to memory, one line per req strobe
    typedef struct packed {
        logic        req;
        logic        w_en;
        cache_addr_t addr;
        line_t       w_data;
    } cache2mem_t;

    // memory to cache
    typedef struct packed {
        logic  ready;
        logic  ack;
        logic  r_valid;
        line_t r_data;
    } mem2cache_t;

    // request already split into write and read strobes, half-word address
    typedef struct packed {
        logic      wr_en;
        logic      rd_en;
        app_addr_t addr;
        line_t     data;
    } app_req_t;

    // command sequencer states
    typedef enum logic [2:0] {
        ST_CALIB,
        ST_IDLE,
        ST_ISSUE_CMD_WDATA,
        ST_ISSUE_CMD,
        ST_ISSUE_WDATA
    } dram_ui_state_e;

endpackage

// ==== hw/dram_ui/dram_ui.sv ====
// DRAM user-interface block
// sequences commands to the controller and returns read lines to the cache
`timescale 1ns/1ps

module dram_ui (
    input  logic                    clk,
    input  logic                    rst,
    input  main_mem_pkg::app_req_t  i_req,
    input  logic                    i_app_rdy,
    input  logic                    i_app_wdf_rdy,
    input  logic                    i_init_calib_complete,
    input  main_mem_pkg::line_t     i_app_rd_data,
    input  logic                    i_app_rd_data_valid,
    output main_mem_pkg::app_addr_t o_app_addr,
    output main_mem_pkg::app_cmd_t  o_app_cmd,
    output logic                    o_app_en,
    output main_mem_pkg::line_t     o_app_wdf_data,
    output logic                    o_app_wdf_wren,
    output main_mem_pkg::mem2cache_t o_mem2cache
);
    import main_mem_pkg::*;

    logic  load_wr;
    logic  load_rd;
    logic  cmd_done;
    logic  wdata_done;
    logic  ready;
    logic  ack;
    logic  r_valid_q;
    line_t r_data_q;

    dram_ui_fsm u_fsm (
        .clk                   (clk),
        .rst                   (rst),
        .i_wr_en               (i_req.wr_en),
        .i_rd_en               (i_req.rd_en),
        .i_app_rdy             (i_app_rdy),
        .i_app_wdf_rdy         (i_app_wdf_rdy),
        .i_init_calib_complete (i_init_calib_complete),
        .o_load_wr             (load_wr),
        .o_load_rd             (load_rd),
        .o_cmd_done            (cmd_done),
        .o_wdata_done          (wdata_done),
        .o_ready               (ready),
        .o_ack                 (ack)
    );

    dram_ui_cmd_stage u_cmd_stage (
        .clk            (clk),
        .rst            (rst),
        .i_load_wr      (load_wr),
        .i_load_rd      (load_rd),
        .i_cmd_done     (cmd_done),
        .i_wdata_done   (wdata_done),
        .i_addr         (i_req.addr),
        .i_data         (i_req.data),
        .o_app_addr     (o_app_addr),
        .o_app_cmd      (o_app_cmd),
        .o_app_en       (o_app_en),
        .o_app_wdf_data (o_app_wdf_data),
        .o_app_wdf_wren (o_app_wdf_wren)
    );

    // read valid pulse, one cycle behind the controller
    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid_q <= 1'b0;
        end else begin
            r_valid_q <= i_app_rd_data_valid;
        end
    end

    // held until the next read returns
    always_ff @(posedge clk) begin
        if (i_app_rd_data_valid) begin
            r_data_q <= i_app_rd_data;
        end
    end

    always_comb begin
        o_mem2cache.ready   = ready;
        o_mem2cache.ack     = ack;
        o_mem2cache.r_valid = r_valid_q;
        o_mem2cache.r_data  = r_data_q;
    end

endmodule

// ==== hw/dram_ui/dram_ui_cmd_stage.sv ====
// application port command stage
// holds command, address and write data, drops each enable once accepted
`timescale 1ns/1ps

module dram_ui_cmd_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_load_wr,
    input  logic                    i_load_rd,
    input  logic                    i_cmd_done,
    input  logic                    i_wdata_done,
    input  main_mem_pkg::app_addr_t i_addr,
    input  main_mem_pkg::line_t     i_data,
    output main_mem_pkg::app_addr_t o_app_addr,
    output main_mem_pkg::app_cmd_t  o_app_cmd,
    output logic                    o_app_en,
    output main_mem_pkg::line_t     o_app_wdf_data,
    output logic                    o_app_wdf_wren
);
    import main_mem_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_app_addr     <= '0;
            o_app_cmd      <= '0;
            o_app_en       <= 1'b0;
            o_app_wdf_data <= '0;
            o_app_wdf_wren <= 1'b0;
        end else if (i_load_wr) begin
            // command and data go out together
            o_app_addr     <= i_addr;
            o_app_cmd      <= CMD_WRITE;
            o_app_en       <= 1'b1;
            o_app_wdf_data <= i_data;
            o_app_wdf_wren <= 1'b1;
        end else if (i_load_rd) begin
            o_app_addr     <= i_addr;
            o_app_cmd      <= CMD_READ;
            o_app_en       <= 1'b1;
            o_app_wdf_wren <= 1'b0;
        end else begin
            // each half retires on its own acceptance
            if (i_cmd_done) begin
                o_app_en <= 1'b0;
            end
            if (i_wdata_done) begin
                o_app_wdf_wren <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/dram_ui/dram_ui_fsm.sv ====
// DRAM command sequencer
// waits for calibration, tracks command and write-data acceptance, pulses ack
`timescale 1ns/1ps

module dram_ui_fsm (
    input  logic clk,
    input  logic rst,
    input  logic i_wr_en,
    input  logic i_rd_en,
    input  logic i_app_rdy,
    input  logic i_app_wdf_rdy,
    input  logic i_init_calib_complete,
    output logic o_load_wr,
    output logic o_load_rd,
    output logic o_cmd_done,
    output logic o_wdata_done,
    output logic o_ready,
    output logic o_ack
);
    import main_mem_pkg::*;

    dram_ui_state_e state_q;
    dram_ui_state_e state_d;
    logic           ack_d;
    logic           ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_CALIB;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q   <= ack_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        ack_d        = 1'b0;
        o_load_wr    = 1'b0;
        o_load_rd    = 1'b0;
        o_cmd_done   = 1'b0;
        o_wdata_done = 1'b0;
        case (state_q)
            ST_CALIB: begin
                if (i_init_calib_complete) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                // write wins if both strobes ever arrive together
                if (i_wr_en) begin
                    o_load_wr = 1'b1;
                    state_d   = ST_ISSUE_CMD_WDATA;
                end else if (i_rd_en) begin
                    o_load_rd = 1'b1;
                    state_d   = ST_ISSUE_CMD;
                end
            end
            ST_ISSUE_CMD_WDATA: begin
                o_cmd_done   = i_app_rdy;
                o_wdata_done = i_app_wdf_rdy;
                if (i_app_rdy && i_app_wdf_rdy) begin
                    ack_d   = 1'b1;
                    state_d = ST_IDLE;
                end else if (i_app_rdy) begin
                    // command taken, data still pending
                    state_d = ST_ISSUE_WDATA;
                end else if (i_app_wdf_rdy) begin
                    state_d = ST_ISSUE_CMD;
                end
            end
            ST_ISSUE_CMD: begin
                o_cmd_done = i_app_rdy;
                if (i_app_rdy) begin
                    ack_d   = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            ST_ISSUE_WDATA: begin
                o_wdata_done = i_app_wdf_rdy;
                if (i_app_wdf_rdy) begin
                    ack_d   = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign o_ready = (state_q == ST_IDLE);
    assign o_ack   = ack_q;

endmodule

// ==== hw/main_mem.sv ====
// main memory, DRAM side
// converts cache line requests and issues them on the controller application port
`timescale 1ns/1ps

module main_mem (
    input  logic                    clk,
    input  logic                    rst,
    input  main_mem_pkg::cache2mem_t i_cache2mem,
    output main_mem_pkg::mem2cache_t o_mem2cache,
    input  logic                    i_app_rdy,
    input  logic                    i_app_wdf_rdy,
    input  logic                    i_init_calib_complete,
    input  main_mem_pkg::line_t     i_app_rd_data,
    input  logic                    i_app_rd_data_valid,
    output main_mem_pkg::app_addr_t o_app_addr,
    output main_mem_pkg::app_cmd_t  o_app_cmd,
    output logic                    o_app_en,
    output main_mem_pkg::line_t     o_app_wdf_data,
    output logic                    o_app_wdf_wren
);
    import main_mem_pkg::*;

    app_req_t app_req;

    always_comb begin
        app_req.wr_en = i_cache2mem.req & i_cache2mem.w_en;
        app_req.rd_en = i_cache2mem.req & ~i_cache2mem.w_en;
        // byte address to half-word address, top bit zero
        app_req.addr  = {1'b0, i_cache2mem.addr[APP_ADDR_WIDTH-1:1]};
        app_req.data  = i_cache2mem.w_data;
    end

    dram_ui u_dram_ui (
        .clk                   (clk),
        .rst                   (rst),
        .i_req                 (app_req),
        .i_app_rdy             (i_app_rdy),
        .i_app_wdf_rdy         (i_app_wdf_rdy),
        .i_init_calib_complete (i_init_calib_complete),
        .i_app_rd_data         (i_app_rd_data),
        .i_app_rd_data_valid   (i_app_rd_data_valid),
        .o_app_addr            (o_app_addr),
        .o_app_cmd             (o_app_cmd),
        .o_app_en              (o_app_en),
        .o_app_wdf_data        (o_app_wdf_data),
        .o_app_wdf_wren        (o_app_wdf_wren),
        .o_mem2cache           (o_mem2cache)
    );

endmodule

// ==== test/app_port_model.sv ====
// behavioral model of the DRAM controller application port
// random readiness, line store by address and in-order read returns
`timescale 1ns/1ps

module app_port_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_cmd_first,
    input  logic                    i_data_first,
    input  main_mem_pkg::app_addr_t i_app_addr,
    input  main_mem_pkg::app_cmd_t  i_app_cmd,
    input  logic                    i_app_en,
    input  main_mem_pkg::line_t     i_app_wdf_data,
    input  logic                    i_app_wdf_wren,
    output logic                    o_app_rdy,
    output logic                    o_app_wdf_rdy,
    output logic                    o_init_calib_complete,
    output main_mem_pkg::line_t     o_app_rd_data,
    output logic                    o_app_rd_data_valid,
    output int                      o_cmd_count,
    output int                      o_wdata_count,
    output main_mem_pkg::app_addr_t o_last_addr,
    output int                      o_err_count
);
    import main_mem_pkg::*;

    line_t     store [app_addr_t];
    line_t     rd_data_q [$];
    int        rd_due_q [$];
    integer    seed;
    int        cycle;
    int        calib_wait;
    int        due;
    logic      pend_cmd;
    logic      pend_data;
    app_addr_t pend_addr;
    line_t     pend_wdata;
    line_t     rd_line;

    initial begin
        seed                  = 32628;
        cycle                 = 0;
        calib_wait            = 0;
        pend_cmd              = 1'b0;
        pend_data             = 1'b0;
        o_app_rdy             = 1'b0;
        o_app_wdf_rdy         = 1'b0;
        o_init_calib_complete = 1'b0;
        o_app_rd_data         = '0;
        o_app_rd_data_valid   = 1'b0;
        o_cmd_count           = 0;
        o_wdata_count         = 0;
        o_last_addr           = '0;
        o_err_count           = 0;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst) begin
            calib_wait = 0;
            o_init_calib_complete <= 1'b0;
            o_app_rdy             <= 1'b0;
            o_app_wdf_rdy         <= 1'b0;
            o_app_rd_data_valid   <= 1'b0;
        end else begin
            if (calib_wait < 10) begin
                calib_wait = calib_wait + 1;
            end else begin
                o_init_calib_complete <= 1'b1;
            end

            // directed orders hold back one ready until the other part is gone
            if (i_cmd_first) begin
                o_app_rdy     <= 1'b1;
                o_app_wdf_rdy <= i_app_wdf_wren && !i_app_en;
            end else if (i_data_first) begin
                o_app_wdf_rdy <= 1'b1;
                o_app_rdy     <= i_app_en && !i_app_wdf_wren;
            end else begin
                o_app_rdy     <= ($random(seed) & 3) != 0;
                o_app_wdf_rdy <= ($random(seed) & 3) != 0;
            end

            if (i_app_wdf_wren && o_app_wdf_rdy) begin
                o_wdata_count <= o_wdata_count + 1;
                if (pend_cmd) begin
                    store[pend_addr] = i_app_wdf_data;
                    pend_cmd = 1'b0;
                end else begin
                    if (pend_data) begin
                        $display("app port model: write data accepted twice for one write");
                        o_err_count <= o_err_count + 1;
                    end
                    pend_data  = 1'b1;
                    pend_wdata = i_app_wdf_data;
                end
            end

            if (i_app_en && o_app_rdy) begin
                o_cmd_count <= o_cmd_count + 1;
                o_last_addr <= i_app_addr;
                if (i_app_cmd == CMD_WRITE && pend_data) begin
                    store[i_app_addr] = pend_wdata;
                    pend_data = 1'b0;
                end else if (i_app_cmd == CMD_WRITE) begin
                    pend_cmd  = 1'b1;
                    pend_addr = i_app_addr;
                end else if (i_app_cmd == CMD_READ) begin
                    if (store.exists(i_app_addr)) begin
                        rd_line = store[i_app_addr];
                    end else begin
                        rd_line = '0;
                    end
                    // returns stay in order, one per cycle at most
                    due = cycle + 3 + ($unsigned($random(seed)) % 4);
                    if (rd_due_q.size() > 0 && due <= rd_due_q[$]) begin
                        due = rd_due_q[$] + 1;
                    end
                    rd_due_q.push_back(due);
                    rd_data_q.push_back(rd_line);
                end else begin
                    $display("app port model: unknown command code %0h", i_app_cmd);
                    o_err_count <= o_err_count + 1;
                end
            end

            if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                o_app_rd_data_valid <= 1'b1;
                o_app_rd_data       <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end else begin
                // junk on the data bus while not valid
                o_app_rd_data_valid <= 1'b0;
                o_app_rd_data <= {$random(seed), $random(seed), $random(seed), $random(seed)};
            end
        end
    end

endmodule

// ==== test/tb_clock.sv ====
// testbench clock and reset
// 20 ns clock, reset held high for the first four rising edges
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

    always #10 clk = ~clk;

endmodule

// ==== test/tb_main_mem.sv ====
// testbench for the DRAM-side main memory
// cache requests against a controller model with reads checked against a reference
`timescale 1ns/1ps

module tb_main_mem;
    import main_mem_pkg::*;

    localparam int          NUM_LINES      = 8;
    localparam int          RANDOM_OPS     = 40;
    localparam int          NUM_REQUESTS   = 2 + 4 + NUM_LINES + RANDOM_OPS + NUM_LINES;
    localparam int          TIMEOUT_CYCLES = NUM_REQUESTS * 40 + 200;
    localparam cache_addr_t LINE_BASE      = 32'h0000_1000;

    logic       clk;
    logic       rst;
    cache2mem_t cache_req;
    mem2cache_t mem_resp;
    logic       app_rdy;
    logic       app_wdf_rdy;
    logic       init_calib_complete;
    logic       app_rd_data_valid;
    line_t      app_rd_data;
    app_addr_t  app_addr;
    app_cmd_t   app_cmd;
    logic       app_en;
    line_t      app_wdf_data;
    logic       app_wdf_wren;
    logic       cmd_first;
    logic       data_first;
    int         cmd_count;
    int         wdata_count;
    app_addr_t  last_addr;
    int         model_errs;

    line_t      ref_mem [app_addr_t];
    line_t      exp_q [$];
    line_t      exp_line;
    line_t      last_rdata;
    logic       rdata_known   = 1'b0;
    int         errors        = 0;
    int         tests_run     = 0;
    int         tests_failed  = 0;
    int         requests_done = 0;
    int         reads_issued  = 0;
    int         ack_count     = 0;
    int         rvalid_count  = 0;
    integer     seed          = 32628;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    main_mem dut0 (
        .clk                   (clk),
        .rst                   (rst),
        .i_cache2mem           (cache_req),
        .o_mem2cache           (mem_resp),
        .i_app_rdy             (app_rdy),
        .i_app_wdf_rdy         (app_wdf_rdy),
        .i_init_calib_complete (init_calib_complete),
        .i_app_rd_data         (app_rd_data),
        .i_app_rd_data_valid   (app_rd_data_valid),
        .o_app_addr            (app_addr),
        .o_app_cmd             (app_cmd),
        .o_app_en              (app_en),
        .o_app_wdf_data        (app_wdf_data),
        .o_app_wdf_wren        (app_wdf_wren)
    );

    app_port_model u_model (
        .clk                   (clk),
        .rst                   (rst),
        .i_cmd_first           (cmd_first),
        .i_data_first          (data_first),
        .i_app_addr            (app_addr),
        .i_app_cmd             (app_cmd),
        .i_app_en              (app_en),
        .i_app_wdf_data        (app_wdf_data),
        .i_app_wdf_wren        (app_wdf_wren),
        .o_app_rdy             (app_rdy),
        .o_app_wdf_rdy         (app_wdf_rdy),
        .o_init_calib_complete (init_calib_complete),
        .o_app_rd_data         (app_rd_data),
        .o_app_rd_data_valid   (app_rd_data_valid),
        .o_cmd_count           (cmd_count),
        .o_wdata_count         (wdata_count),
        .o_last_addr           (last_addr),
        .o_err_count           (model_errs)
    );

    // half-word address has the low bit dropped and a zero on top
    function automatic app_addr_t to_app_addr(input cache_addr_t addr);
        cache_addr_t half;
        half = addr >> 1;
        half[APP_ADDR_WIDTH-1] = 1'b0;
        return app_addr_t'(half);
    endfunction

    // expected memory contents with unwritten lines as zero
    function automatic line_t ref_access(input logic w, input app_addr_t addr, input line_t data);
        if (w) begin
            ref_mem[addr] = data;
            return data;
        end
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return '0;
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] got);
        if (got !== exp) begin
            $display("CHECK FAILED %s: expected %0h, got %0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic issue_request(input logic w, input cache_addr_t addr, input line_t data);
        int        cmd_before;
        int        wdata_before;
        app_addr_t exp_addr;
        cmd_before   = cmd_count;
        wdata_before = wdata_count;
        exp_addr     = to_app_addr(addr);
        @(posedge clk);
        while (!mem_resp.ready) begin
            @(posedge clk);
        end
        cache_req.req    <= 1'b1;
        cache_req.w_en   <= w;
        cache_req.addr   <= addr;
        cache_req.w_data <= data;
        if (w) begin
            void'(ref_access(1'b1, exp_addr, data));
        end else begin
            exp_q.push_back(ref_access(1'b0, exp_addr, '0));
            reads_issued++;
        end
        @(posedge clk);
        cache_req.req <= 1'b0;
        @(posedge clk);
        check_value("ready after strobe", 0, mem_resp.ready);
        while (!mem_resp.ack) begin
            @(posedge clk);
        end
        requests_done++;
        check_value("ready at ack", 1, mem_resp.ready);
        check_value("commands accepted", 1, cmd_count - cmd_before);
        check_value("write data accepted", w, wdata_count - wdata_before);
        check_value("o_app_addr", exp_addr, last_addr);
    endtask

    // waits for outstanding reads and reports the test
    task automatic finish_test(input int num, input string name, input int errs_before);
        int errs;
        @(posedge clk);
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
        check_value("ack count", requests_done, ack_count);
        errs = errors + model_errs - errs_before;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errs);
        end
    endtask

    // response checker
    always @(posedge clk) begin
        if (!rst) begin
            if (mem_resp.ack) begin
                ack_count++;
            end
            if (mem_resp.r_valid) begin
                rvalid_count++;
                if (exp_q.size() == 0) begin
                    $display("r_valid pulsed with no read outstanding");
                    errors++;
                end else begin
                    exp_line = exp_q.pop_front();
                    check_value("r_data", exp_line, mem_resp.r_data);
                end
                last_rdata  = mem_resp.r_data;
                rdata_known = 1'b1;
            end else if (rdata_known && mem_resp.r_data !== last_rdata) begin
                check_value("r_data held", last_rdata, mem_resp.r_data);
                last_rdata = mem_resp.r_data;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin : run_tests
        int          errs_before;
        int          idx;
        logic [31:0] rnd;
        line_t       data;
        cache_req  = '0;
        cmd_first  = 1'b0;
        data_first = 1'b0;

        // quiet until calibration and ready one cycle later
        errs_before = 0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        while (!init_calib_complete) begin
            check_value("ready", 0, mem_resp.ready);
            check_value("ack", 0, mem_resp.ack);
            check_value("r_valid", 0, mem_resp.r_valid);
            check_value("o_app_en", 0, app_en);
            check_value("o_app_wdf_wren", 0, app_wdf_wren);
            @(posedge clk);
        end
        check_value("ready", 0, mem_resp.ready);
        @(posedge clk);
        check_value("ready", 1, mem_resp.ready);
        repeat (3) begin
            @(posedge clk);
            check_value("o_app_en", 0, app_en);
            check_value("o_app_wdf_wren", 0, app_wdf_wren);
        end
        finish_test(1, "reset and calibration", errs_before);

        // upper address bits fall outside the app address
        errs_before = errors + model_errs;
        issue_request(1'b1, 32'hfc00_0240, {4{32'hc0de_5a5a}});
        issue_request(1'b0, 32'hfc00_0240, '0);
        finish_test(2, "write then read", errs_before);

        // command and write data accepted in separate cycles
        errs_before = errors + model_errs;
        cmd_first <= 1'b1;
        issue_request(1'b1, 32'h0000_0400, {32'h1111_0001, 32'h2222_0002, 32'h3333_0003,
                                            32'h4444_0004});
        cmd_first  <= 1'b0;
        data_first <= 1'b1;
        issue_request(1'b1, 32'h0000_0410, {32'h5555_0005, 32'h6666_0006, 32'h7777_0007,
                                            32'h8888_0008});
        data_first <= 1'b0;
        issue_request(1'b0, 32'h0000_0400, '0);
        issue_request(1'b0, 32'h0000_0410, '0);
        finish_test(3, "split acceptance", errs_before);

        // unwritten lines first and random traffic after
        errs_before = errors + model_errs;
        for (idx = 0; idx < NUM_LINES; idx++) begin
            issue_request(1'b0, LINE_BASE + idx * 16, '0);
        end
        repeat (RANDOM_OPS) begin
            idx  = $unsigned($random(seed)) % NUM_LINES;
            rnd  = $random(seed);
            data = {$random(seed), $random(seed), $random(seed), $random(seed)};
            issue_request(rnd[0], LINE_BASE + idx * 16, data);
        end
        finish_test(4, "random traffic", errs_before);

        // final read-back with one r_valid per read overall
        errs_before = errors + model_errs;
        for (idx = 0; idx < NUM_LINES; idx++) begin
            issue_request(1'b0, LINE_BASE + idx * 16, '0);
        end
        repeat (10) @(posedge clk);
        check_value("r_valid count", reads_issued, rvalid_count);
        finish_test(5, "read data hold", errs_before);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors + model_errs);
        if (tests_failed == 0 && errors + model_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
